// File: source/pma_settings.svh
// Build-time settings for the PMA checker.
// Only one configuration is built, so these are macros and not parameters.
// The region index type in pma_pkg is 3 bits wide and must cover the count.

`ifndef PMA_SETTINGS_SVH
`define PMA_SETTINGS_SVH

// Number of runtime-programmable address regions
`define PMA_NUM_REGIONS 8

// Inclusive byte bounds of the debug module window
// A debug-mode access in here bypasses the region bank
`define PMA_DM_START 32'h1A11_0000
`define PMA_DM_END   32'h1A11_0FFF

`endif

// File: source/pma_pkg.sv
// Shared types for the PMA checker.
// Region bounds count 4-byte words, so the byte value of a bound is 34 bits
// wide and an exclusive upper bound can reach 2^32.

package pma_pkg;

  // Byte address of a request
  typedef logic [31:0] pma_addr_t;

  // Region bound in words, shift left by two for the byte value
  typedef logic [31:0] pma_word_addr_t;

  // Attribute vector, bit positions below
  typedef logic [3:0] pma_attr_t;

  // Index into the region bank
  typedef logic [2:0] pma_region_idx_t;

  // Main memory, as opposed to I/O
  localparam int PMA_ATTR_MAIN       = 0;

  // Writes may be buffered on the way out
  localparam int PMA_ATTR_BUFFERABLE = 1;

  // Accesses may be cached
  localparam int PMA_ATTR_CACHEABLE  = 2;

  // Memory carries integrity checking
  localparam int PMA_ATTR_INTEGRITY  = 3;

endpackage

// File: source/pma_region_cfg.sv
// Register bank holding the programmable PMA regions.
// One region is written per cycle through cfg_we_i. The low bound is
// inclusive and the high bound exclusive, both in words.
// Only the enables are reset, so every region starts disabled.

`timescale 1ns/1ps

`include "pma_settings.svh"

module pma_region_cfg (
  input  logic                     clk,
  input  logic                     rst_i,

  input  logic                     cfg_we_i,
  input  pma_pkg::pma_region_idx_t cfg_idx_i,
  input  pma_pkg::pma_word_addr_t  cfg_low_i,
  input  pma_pkg::pma_word_addr_t  cfg_high_i,
  input  pma_pkg::pma_attr_t       cfg_attr_i,
  input  logic                     cfg_en_i,

  output logic [`PMA_NUM_REGIONS-1:0] region_en_o,
  output pma_pkg::pma_word_addr_t     region_low_o  [`PMA_NUM_REGIONS],
  output pma_pkg::pma_word_addr_t     region_high_o [`PMA_NUM_REGIONS],
  output pma_pkg::pma_attr_t          region_attr_o [`PMA_NUM_REGIONS]
);

  logic [`PMA_NUM_REGIONS-1:0] en_q;
  pma_pkg::pma_word_addr_t     low_q  [`PMA_NUM_REGIONS];
  pma_pkg::pma_word_addr_t     high_q [`PMA_NUM_REGIONS];
  pma_pkg::pma_attr_t          attr_q [`PMA_NUM_REGIONS];

  // Region enables
  always_ff @(posedge clk) begin
    if (rst_i) begin
      en_q <= '0;
    end else if (cfg_we_i) begin
      en_q[cfg_idx_i] <= cfg_en_i;
    end
  end

  // Bounds and attributes only matter while the region is enabled
  always_ff @(posedge clk) begin
    if (cfg_we_i) begin
      low_q[cfg_idx_i]  <= cfg_low_i;
      high_q[cfg_idx_i] <= cfg_high_i;
      attr_q[cfg_idx_i] <= cfg_attr_i;
    end
  end

  // The comparators see the registered values, so a write
  // affects requests from the next cycle on
  assign region_en_o   = en_q;
  assign region_low_o  = low_q;
  assign region_high_o = high_q;
  assign region_attr_o = attr_q;

  // Software must never address a region that is not built
  a_cfg_idx_in_range: assert property (
    @(posedge clk) disable iff (rst_i)
    cfg_we_i |-> (int'(cfg_idx_i) <= `PMA_NUM_REGIONS - 1)
  ) else $error("PMA config write to region %0d, only %0d regions built",
                cfg_idx_i, `PMA_NUM_REGIONS);

endmodule

// File: source/pma_region_match.sv
// Address comparator for one PMA region, stage 1 of the checker.
// The bounds are widened to bytes on a 34-bit scale so that a high bound of
// 2^32 covers the top of the address space.
// hit_o is only meaningful in the cycle after a valid request.

`timescale 1ns/1ps

module pma_region_match (
  input  logic                    clk,
  input  logic                    rst_i,

  input  logic                    req_valid_i,
  input  pma_pkg::pma_addr_t      req_addr_i,

  input  logic                    region_en_i,
  input  pma_pkg::pma_word_addr_t region_low_i,
  input  pma_pkg::pma_word_addr_t region_high_i,
  input  pma_pkg::pma_attr_t      region_attr_i,

  output logic                    hit_o,
  output pma_pkg::pma_attr_t      attr_o
);

  logic [33:0] low_byte;
  logic [33:0] high_byte;
  logic [33:0] addr_byte;
  logic        match;

  assign low_byte  = {region_low_i, 2'b00};
  assign high_byte = {region_high_i, 2'b00};
  assign addr_byte = {2'b00, req_addr_i};

  // Low bound inclusive, high bound exclusive
  assign match = region_en_i && (low_byte <= addr_byte) && (addr_byte < high_byte);

  // The hit drops whenever no request is presented
  always_ff @(posedge clk) begin
    if (rst_i) begin
      hit_o <= 1'b0;
    end else begin
      hit_o <= req_valid_i && match;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      attr_o <= region_attr_i;
    end
  end

  // A disabled region can never report a hit, even if it is disabled
  // in the same cycle that the request arrives
  a_hit_needs_enable: assert property (
    @(posedge clk) disable iff (rst_i)
    hit_o |-> $past(region_en_i)
  ) else $error("PMA region hit without the region being enabled");

endmodule

// File: source/pma_resolve.sv
// Result stage of the PMA checker, stage 2.
// Picks the lowest-index hit, applies the debug window override and the
// default of all attributes cleared, then derives the allow bit.
// Fetches need main memory. Data accesses to I/O must be aligned and
// outside push/pop sequences.

`timescale 1ns/1ps

`include "pma_settings.svh"

module pma_resolve (
  input  logic                        clk,
  input  logic                        rst_i,

  input  logic                        s1_valid_i,
  input  pma_pkg::pma_addr_t          s1_addr_i,
  input  logic                        s1_instr_i,
  input  logic                        s1_load_i,
  input  logic                        s1_dbg_i,
  input  logic                        s1_misaligned_i,
  input  logic                        s1_pushpop_i,

  input  logic [`PMA_NUM_REGIONS-1:0] hit_i,
  input  pma_pkg::pma_attr_t          attr_i [`PMA_NUM_REGIONS],

  output logic                        status_valid_o,
  output logic                        status_allow_o,
  output pma_pkg::pma_attr_t          status_attr_o
);

  // Debug module accesses are treated as plain main memory
  localparam pma_pkg::pma_attr_t DBG_ATTR = pma_pkg::pma_attr_t'(1 << pma_pkg::PMA_ATTR_MAIN);

  logic               dm_window;
  logic               override_dm;
  logic               any_hit;
  pma_pkg::pma_attr_t hit_attr;
  pma_pkg::pma_attr_t eff_attr;
  logic               is_main;
  logic               allow_instr;
  logic               allow_data;
  logic               allow;

  assign dm_window   = (s1_addr_i >= `PMA_DM_START) && (s1_addr_i <= `PMA_DM_END);
  assign override_dm = s1_dbg_i && dm_window;

  // First match wins, so only take a region while nothing lower has hit
  always_comb begin
    any_hit  = 1'b0;
    hit_attr = '0;
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      if (hit_i[i] && !any_hit) begin
        any_hit  = 1'b1;
        hit_attr = attr_i[i];
      end
    end
  end

  always_comb begin
    if (override_dm) begin
      eff_attr = DBG_ATTR;
    end else if (any_hit) begin
      eff_attr = hit_attr;
    end else begin
      eff_attr = '0;
    end
    // Buffering only makes sense for stores
    if (s1_instr_i || s1_load_i) begin
      eff_attr[pma_pkg::PMA_ATTR_BUFFERABLE] = 1'b0;
    end
  end

  assign is_main     = eff_attr[pma_pkg::PMA_ATTR_MAIN];
  assign allow_instr = is_main;
  assign allow_data  = is_main || (!s1_misaligned_i && !s1_pushpop_i);
  assign allow       = override_dm || (s1_instr_i ? allow_instr : allow_data);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      status_valid_o <= 1'b0;
    end else begin
      status_valid_o <= s1_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid_i) begin
      status_allow_o <= allow;
      status_attr_o  <= eff_attr;
    end
  end

  // The debugger must always reach the debug module, whatever the regions say
  a_dm_always_allowed: assert property (
    @(posedge clk) disable iff (rst_i)
    (s1_valid_i && s1_dbg_i && dm_window) |=>
      (status_valid_o && status_allow_o && status_attr_o == DBG_ATTR)
  ) else $error("PMA refused a debug access to the debug module window");

endmodule

// File: source/pma_checker.sv
// Physical memory attribute checker, top level.
// Two-stage pipeline with a valid strobe and no back-pressure. A result
// appears two cycles after its request and must be taken when valid.
// Region writes affect only requests presented on later cycles.

`timescale 1ns/1ps

`include "pma_settings.svh"

module pma_checker (
  input  logic                     clk,
  input  logic                     rst_i,

  input  logic                     cfg_we_i,
  input  pma_pkg::pma_region_idx_t cfg_idx_i,
  input  pma_pkg::pma_word_addr_t  cfg_low_i,
  input  pma_pkg::pma_word_addr_t  cfg_high_i,
  input  pma_pkg::pma_attr_t       cfg_attr_i,
  input  logic                     cfg_en_i,

  input  logic                     req_valid_i,
  input  pma_pkg::pma_addr_t       req_addr_i,
  input  logic                     req_instr_i,
  input  logic                     req_load_i,
  input  logic                     req_dbg_i,
  input  logic                     req_misaligned_i,
  input  logic                     req_pushpop_i,

  output logic                     status_valid_o,
  output logic                     status_allow_o,
  output pma_pkg::pma_attr_t       status_attr_o
);

  logic [`PMA_NUM_REGIONS-1:0] region_en;
  pma_pkg::pma_word_addr_t     region_low  [`PMA_NUM_REGIONS];
  pma_pkg::pma_word_addr_t     region_high [`PMA_NUM_REGIONS];
  pma_pkg::pma_attr_t          region_attr [`PMA_NUM_REGIONS];

  logic [`PMA_NUM_REGIONS-1:0] hit;
  pma_pkg::pma_attr_t          hit_attr [`PMA_NUM_REGIONS];

  logic                        s1_valid;
  pma_pkg::pma_addr_t          s1_addr;
  logic                        s1_instr;
  logic                        s1_load;
  logic                        s1_dbg;
  logic                        s1_misaligned;
  logic                        s1_pushpop;

  pma_region_cfg u_region_cfg (
    .clk           (clk),
    .rst_i         (rst_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_low_i     (cfg_low_i),
    .cfg_high_i    (cfg_high_i),
    .cfg_attr_i    (cfg_attr_i),
    .cfg_en_i      (cfg_en_i),
    .region_en_o   (region_en),
    .region_low_o  (region_low),
    .region_high_o (region_high),
    .region_attr_o (region_attr)
  );

  for (genvar i = 0; i < `PMA_NUM_REGIONS; i++) begin : gen_regions
    pma_region_match u_match (
      .clk           (clk),
      .rst_i         (rst_i),
      .req_valid_i   (req_valid_i),
      .req_addr_i    (req_addr_i),
      .region_en_i   (region_en[i]),
      .region_low_i  (region_low[i]),
      .region_high_i (region_high[i]),
      .region_attr_i (region_attr[i]),
      .hit_o         (hit[i]),
      .attr_o        (hit_attr[i])
    );
  end

  // Stage 1 side-band, kept in step with the comparator outputs
  always_ff @(posedge clk) begin
    if (rst_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      s1_addr       <= req_addr_i;
      s1_instr      <= req_instr_i;
      s1_load       <= req_load_i;
      s1_dbg        <= req_dbg_i;
      s1_misaligned <= req_misaligned_i;
      s1_pushpop    <= req_pushpop_i;
    end
  end

  pma_resolve u_resolve (
    .clk             (clk),
    .rst_i           (rst_i),
    .s1_valid_i      (s1_valid),
    .s1_addr_i       (s1_addr),
    .s1_instr_i      (s1_instr),
    .s1_load_i       (s1_load),
    .s1_dbg_i        (s1_dbg),
    .s1_misaligned_i (s1_misaligned),
    .s1_pushpop_i    (s1_pushpop),
    .hit_i           (hit),
    .attr_i          (hit_attr),
    .status_valid_o  (status_valid_o),
    .status_allow_o  (status_allow_o),
    .status_attr_o   (status_attr_o)
  );

endmodule

// File: test/pma_checker_tb.sv
// Self-checking testbench for the PMA checker.
// Directed rows come from a table and are applied in stages around region
// writes. After them 200 random requests are checked against a model.
// Every result must appear exactly two cycles after its request.

`timescale 1ns/1ps

`include "pma_settings.svh"

module pma_checker_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_CFG      = 8;
  localparam int NUM_REQ      = 24;
  localparam int NUM_RANDOM   = 200;
  localparam int LATENCY      = 2;
  localparam int WATCHDOG_NS  = (NUM_REQ + NUM_RANDOM + 50) * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD;

  // Request kinds in the table
  localparam int ST = 0;
  localparam int LD = 1;
  localparam int FE = 2;

  logic                     clk;
  logic                     rst_i;
  logic                     cfg_we_i;
  pma_pkg::pma_region_idx_t cfg_idx_i;
  pma_pkg::pma_word_addr_t  cfg_low_i;
  pma_pkg::pma_word_addr_t  cfg_high_i;
  pma_pkg::pma_attr_t       cfg_attr_i;
  logic                     cfg_en_i;
  logic                     req_valid_i;
  pma_pkg::pma_addr_t       req_addr_i;
  logic                     req_instr_i;
  logic                     req_load_i;
  logic                     req_dbg_i;
  logic                     req_misaligned_i;
  logic                     req_pushpop_i;
  logic                     status_valid_o;
  logic                     status_allow_o;
  pma_pkg::pma_attr_t       status_attr_o;

  // Region table, stage 1 is the initial setup and stage 2 the rewrite
  int          cfg_stage [NUM_CFG];
  int          cfg_idx   [NUM_CFG];
  logic [31:0] cfg_low   [NUM_CFG];
  logic [31:0] cfg_high  [NUM_CFG];
  logic [3:0]  cfg_attr  [NUM_CFG];
  logic        cfg_en    [NUM_CFG];
  int          cfg_rows = 0;

  // Request table with the expected results worked out by hand
  int          req_stage [NUM_REQ];
  string       req_name  [NUM_REQ];
  logic [31:0] req_addr  [NUM_REQ];
  int          req_kind  [NUM_REQ];
  logic        req_dbg   [NUM_REQ];
  logic        req_mis   [NUM_REQ];
  logic        req_pp    [NUM_REQ];
  logic        req_allow [NUM_REQ];
  logic [3:0]  req_attr  [NUM_REQ];
  int          req_rows = 0;

  // Copy of the programmed regions for the random model
  logic        shadow_en   [`PMA_NUM_REGIONS];
  logic [31:0] shadow_low  [`PMA_NUM_REGIONS];
  logic [31:0] shadow_high [`PMA_NUM_REGIONS];
  logic [3:0]  shadow_attr [`PMA_NUM_REGIONS];

  string       exp_name_q  [$];
  logic        exp_allow_q [$];
  logic [3:0]  exp_attr_q  [$];
  int          exp_cycle_q [$];

  int          cycle_count = 0;
  integer      seed;

  pma_checker uut (
    .clk              (clk),
    .rst_i            (rst_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_idx_i        (cfg_idx_i),
    .cfg_low_i        (cfg_low_i),
    .cfg_high_i       (cfg_high_i),
    .cfg_attr_i       (cfg_attr_i),
    .cfg_en_i         (cfg_en_i),
    .req_valid_i      (req_valid_i),
    .req_addr_i       (req_addr_i),
    .req_instr_i      (req_instr_i),
    .req_load_i       (req_load_i),
    .req_dbg_i        (req_dbg_i),
    .req_misaligned_i (req_misaligned_i),
    .req_pushpop_i    (req_pushpop_i),
    .status_valid_o   (status_valid_o),
    .status_allow_o   (status_allow_o),
    .status_attr_o    (status_attr_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the DUT stopped returning results", WATCHDOG_NS);
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic report_missing(input string where);
    $display("%0d results never came out %s", exp_name_q.size(), where);
    $display("Verification failed");
    $fatal(1, "Missing results");
  endtask

  task automatic add_cfg(input int stage, input int idx, input logic [31:0] low,
                         input logic [31:0] high, input logic [3:0] attr, input int en);
    cfg_stage[cfg_rows] = stage;
    cfg_idx[cfg_rows]   = idx;
    cfg_low[cfg_rows]   = low;
    cfg_high[cfg_rows]  = high;
    cfg_attr[cfg_rows]  = attr;
    cfg_en[cfg_rows]    = (en != 0);
    cfg_rows++;
  endtask

  task automatic add_req(input int stage, input string name, input logic [31:0] addr,
                         input int kind, input int dbg, input int mis, input int pp,
                         input int allow, input logic [3:0] attr);
    req_stage[req_rows] = stage;
    req_name[req_rows]  = name;
    req_addr[req_rows]  = addr;
    req_kind[req_rows]  = kind;
    req_dbg[req_rows]   = (dbg != 0);
    req_mis[req_rows]   = (mis != 0);
    req_pp[req_rows]    = (pp != 0);
    req_allow[req_rows] = (allow != 0);
    req_attr[req_rows]  = attr;
    req_rows++;
  endtask

  // Bounds are in words. Attribute bits are integrity, cacheable, bufferable, main
  task automatic fill_tables();
    add_cfg(1, 0, 32'h2000_0000, 32'h2000_1000, 4'hD, 1);
    // Region 1 overlaps the top half of region 0
    add_cfg(1, 1, 32'h2000_0800, 32'h2000_4000, 4'h2, 1);
    // I/O region around the debug module window
    add_cfg(1, 2, 32'h0684_0000, 32'h0688_0000, 4'h2, 1);
    add_cfg(1, 3, 32'h0800_0000, 32'h0800_0400, 4'h3, 1);
    add_cfg(1, 4, 32'h0C00_0000, 32'h0C00_0400, 4'hF, 0);
    // Upper bound of 2^32 bytes
    add_cfg(1, 5, 32'h3FFF_FC00, 32'h4000_0000, 4'h1, 1);
    add_cfg(2, 0, 32'h2000_0000, 32'h2000_1000, 4'hD, 0);
    add_cfg(2, 3, 32'h0800_0000, 32'h0800_0400, 4'h0, 1);

    add_req(0, "noreg_store_misaligned", 32'h8000_0000, ST, 0, 1, 0, 0, 4'h0);
    add_req(0, "noreg_store_aligned",    32'h8000_0000, ST, 0, 0, 0, 1, 4'h0);
    add_req(1, "overlap_load",           32'h8000_2000, LD, 0, 0, 0, 1, 4'hD);
    add_req(1, "overlap_store",          32'h8000_3FFC, ST, 0, 0, 0, 1, 4'hD);
    add_req(1, "r0_high_bound",          32'h8000_4000, ST, 0, 1, 0, 0, 4'h2);
    add_req(1, "r0_low_bound",           32'h8000_0000, FE, 0, 0, 0, 1, 4'hD);
    add_req(1, "below_r0_fetch",         32'h7FFF_FFFC, FE, 0, 0, 0, 0, 4'h0);
    add_req(1, "r1_high_bound",          32'h8001_0000, LD, 0, 0, 0, 1, 4'h0);
    add_req(1, "dm_dbg_load",            32'h1A11_0000, LD, 1, 0, 0, 1, 4'h1);
    add_req(1, "dm_dbg_store_pushpop",   32'h1A11_0FFC, ST, 1, 0, 1, 1, 4'h1);
    add_req(1, "dm_nodbg_store_pushpop", 32'h1A11_0FFC, ST, 0, 0, 1, 0, 4'h2);
    add_req(1, "dm_nodbg_fetch",         32'h1A11_0000, FE, 0, 0, 0, 0, 4'h0);
    add_req(1, "dm_dbg_past_window",     32'h1A11_1000, ST, 1, 1, 0, 0, 4'h2);
    add_req(1, "buf_store",              32'h2000_0010, ST, 0, 0, 0, 1, 4'h3);
    add_req(1, "buf_load",               32'h2000_0010, LD, 0, 0, 0, 1, 4'h1);
    add_req(1, "buf_fetch",              32'h2000_0FFC, FE, 0, 0, 0, 1, 4'h1);
    add_req(1, "io_fetch",               32'h8000_8000, FE, 0, 0, 0, 0, 4'h0);
    add_req(1, "disabled_region",        32'h3000_0000, ST, 0, 1, 0, 0, 4'h0);
    add_req(1, "top_region_load",        32'hFFFF_FFFC, LD, 0, 1, 0, 1, 4'h1);
    add_req(1, "top_region_pushpop",     32'hFFFF_F000, ST, 0, 0, 1, 1, 4'h1);
    add_req(2, "r0_disabled_overlap",    32'h8000_2000, ST, 0, 0, 0, 1, 4'h2);
    add_req(2, "r0_disabled_only",       32'h8000_0000, ST, 0, 0, 1, 0, 4'h0);
    add_req(2, "r3_rewritten_store",     32'h2000_0010, ST, 0, 1, 0, 0, 4'h0);
    add_req(2, "r3_rewritten_fetch",     32'h2000_0010, FE, 0, 0, 0, 0, 4'h0);
  endtask

  task automatic write_region(input int idx, input logic [31:0] low, input logic [31:0] high,
                              input logic [3:0] attr, input logic en);
    @(negedge clk);
    cfg_we_i         = 1'b1;
    cfg_idx_i        = pma_pkg::pma_region_idx_t'(idx);
    cfg_low_i        = low;
    cfg_high_i       = high;
    cfg_attr_i       = attr;
    cfg_en_i         = en;
    shadow_en[idx]   = en;
    shadow_low[idx]  = low;
    shadow_high[idx] = high;
    shadow_attr[idx] = attr;
  endtask

  task automatic end_config();
    @(negedge clk);
    cfg_we_i = 1'b0;
  endtask

  task automatic drive_request(input string name, input logic [31:0] addr,
                               input logic instr, input logic load, input logic dbg,
                               input logic mis, input logic pp,
                               input logic exp_allow, input logic [3:0] exp_attr);
    @(negedge clk);
    req_valid_i      = 1'b1;
    req_addr_i       = addr;
    req_instr_i      = instr;
    req_load_i       = load;
    req_dbg_i        = dbg;
    req_misaligned_i = mis;
    req_pushpop_i    = pp;
    exp_name_q.push_back(name);
    exp_allow_q.push_back(exp_allow);
    exp_attr_q.push_back(exp_attr);
    exp_cycle_q.push_back(cycle_count + LATENCY);
  endtask

  // The last result is checked one edge before this returns
  task automatic drain();
    @(negedge clk);
    req_valid_i = 1'b0;
    repeat (LATENCY) @(negedge clk);
  endtask

  task automatic check_result();
    string name;
    name = exp_name_q.pop_front();
    check_value({name, " latency"}, 32'(exp_cycle_q.pop_front()), 32'(cycle_count));
    check_value({name, " allow"}, 32'(exp_allow_q.pop_front()), 32'(status_allow_o));
    check_value({name, " attr"}, 32'(exp_attr_q.pop_front()), 32'(status_attr_o));
  endtask

  // Outputs change on the rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!rst_i && status_valid_o === 1'b1) begin
      if (exp_name_q.size() == 0) begin
        $display("A result came out with no request waiting for it");
        $display("Verification failed");
        $fatal(1, "Unexpected result");
      end else begin
        check_result();
      end
    end
  end

  // Returns allow in bit 4 above the attributes
  function automatic logic [4:0] model_status(input logic [31:0] addr, input logic instr,
                                              input logic load, input logic dbg,
                                              input logic mis, input logic pp);
    logic [3:0]  attr;
    logic        found;
    logic        in_dm;
    logic        allow;
    logic [33:0] byte_addr;
    attr      = 4'h0;
    found     = 1'b0;
    byte_addr = {2'b00, addr};
    in_dm     = dbg && (addr >= `PMA_DM_START) && (addr <= `PMA_DM_END);
    if (in_dm) begin
      attr[pma_pkg::PMA_ATTR_MAIN] = 1'b1;
    end else begin
      for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
        if (!found && shadow_en[i] && ({shadow_low[i], 2'b00} <= byte_addr)
            && (byte_addr < {shadow_high[i], 2'b00})) begin
          found = 1'b1;
          attr  = shadow_attr[i];
        end
      end
    end
    if (instr || load) begin
      attr[pma_pkg::PMA_ATTR_BUFFERABLE] = 1'b0;
    end
    if (in_dm) begin
      allow = 1'b1;
    end else if (instr) begin
      allow = attr[pma_pkg::PMA_ATTR_MAIN];
    end else begin
      allow = attr[pma_pkg::PMA_ATTR_MAIN] || (!mis && !pp);
    end
    return {allow, attr};
  endfunction

  // Bases sit just below region edges so the offsets cross them
  function automatic logic [31:0] random_base(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h8000_0000;
      3'd1:    return 32'h8000_1000;
      3'd2:    return 32'h1A11_0000;
      3'd3:    return 32'h2000_0000;
      3'd4:    return 32'h2FFF_F000;
      3'd5:    return 32'hFFFF_E000;
      default: return 32'h1A10_F000;
    endcase
  endfunction

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    logic [4:0]  expected;
    seed             = 32'h77ebcb92;
    rst_i            = 1'b1;
    cfg_we_i         = 1'b0;
    cfg_idx_i        = '0;
    cfg_low_i        = '0;
    cfg_high_i       = '0;
    cfg_attr_i       = '0;
    cfg_en_i         = 1'b0;
    req_valid_i      = 1'b0;
    req_addr_i       = '0;
    req_instr_i      = 1'b0;
    req_load_i       = 1'b0;
    req_dbg_i        = 1'b0;
    req_misaligned_i = 1'b0;
    req_pushpop_i    = 1'b0;
    for (int i = 0; i < `PMA_NUM_REGIONS; i++) begin
      shadow_en[i] = 1'b0;
    end
    fill_tables();

    repeat (RESET_CYCLES) @(negedge clk);
    rst_i = 1'b0;
    repeat (3) @(negedge clk);
    check_value("valid_low_after_reset", 32'd0, 32'(status_valid_o));

    for (int stage = 0; stage < 3; stage++) begin
      for (int c = 0; c < NUM_CFG; c++) begin
        if (cfg_stage[c] == stage) begin
          write_region(cfg_idx[c], cfg_low[c], cfg_high[c], cfg_attr[c], cfg_en[c]);
        end
      end
      end_config();
      for (int q = 0; q < NUM_REQ; q++) begin
        if (req_stage[q] == stage) begin
          drive_request(req_name[q], req_addr[q], req_kind[q] == FE, req_kind[q] == LD,
                        req_dbg[q], req_mis[q], req_pp[q], req_allow[q], req_attr[q]);
        end
      end
      drain();
      if (exp_name_q.size() != 0) begin
        report_missing($sformatf("in table stage %0d", stage));
      end
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = $random(seed);
      if (r[2:0] == 3'd7) begin
        addr = $random(seed);
      end else begin
        addr = random_base(r[2:0]) + {19'd0, r[15:3]};
      end
      expected = model_status(addr, r[17:16] == 2'd2, r[17:16] == 2'd1, r[18], r[19], r[20]);
      drive_request($sformatf("random_%0d", n), addr, r[17:16] == 2'd2, r[17:16] == 2'd1,
                    r[18], r[19], r[20], expected[4], expected[3:0]);
    end
    drain();

    if (exp_name_q.size() != 0) begin
      report_missing("at the end of the run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// File: filelist.f
+incdir+source
source/pma_pkg.sv
source/pma_region_cfg.sv
source/pma_region_match.sv
source/pma_resolve.sv
source/pma_checker.sv
test/pma_checker_tb.sv

// File: Makefile
# Verilator flow for the PMA checker
# A failing check ends the run with $fatal, so make sim fails with it

VERILATOR  ?= verilator
TOP        := pma_checker_tb
RTL_TOP    := pma_checker
FILELIST   := filelist.f
INC_DIR    := source
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --timing --assert -j 0
RTL_FILES  := $(filter source/%.sv,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
